/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

  // base opcodes, instr[6:0]
  localparam logic [6:0] opcode_load         = 7'b0000011;
  localparam logic [6:0] opcode_store        = 7'b0100011;
  localparam logic [6:0] opcode_r_type       = 7'b0110011;
  localparam logic [6:0] opcode_i_type       = 7'b0010011;
  localparam logic [6:0] opcode_b_type       = 7'b1100011;
  localparam logic [6:0] opcode_jal          = 7'b1101111;
  localparam logic [6:0] opcode_jalr         = 7'b1100111;
  localparam logic [6:0] opcode_u_type_lui   = 7'b0110111;
  localparam logic [6:0] opcode_u_type_auipc = 7'b0010111;
  localparam logic [6:0] opcode_syscall_csr  = 7'b1110011;

  localparam logic [2:0] funct3_lb  = 3'b000;
  localparam logic [2:0] funct3_lh  = 3'b001;
  localparam logic [2:0] funct3_lw  = 3'b010;
  localparam logic [2:0] funct3_lbu = 3'b100;
  localparam logic [2:0] funct3_lhu = 3'b101;

  localparam logic [2:0] funct3_sb = 3'b000;
  localparam logic [2:0] funct3_sh = 3'b001;
  localparam logic [2:0] funct3_sw = 3'b010;

  localparam logic [2:0] funct3_beq  = 3'b000;
  localparam logic [2:0] funct3_bne  = 3'b001;
  localparam logic [2:0] funct3_blt  = 3'b100;
  localparam logic [2:0] funct3_bge  = 3'b101;
  localparam logic [2:0] funct3_bltu = 3'b110;
  localparam logic [2:0] funct3_bgeu = 3'b111;

  // shared by R type and I type alu ops
  localparam logic [2:0] funct3_add  = 3'b000;  // also sub
  localparam logic [2:0] funct3_sll  = 3'b001;
  localparam logic [2:0] funct3_slt  = 3'b010;
  localparam logic [2:0] funct3_sltu = 3'b011;
  localparam logic [2:0] funct3_xor  = 3'b100;
  localparam logic [2:0] funct3_srl  = 3'b101;  // also sra
  localparam logic [2:0] funct3_or   = 3'b110;
  localparam logic [2:0] funct3_and  = 3'b111;

  localparam logic [2:0] funct3_ecall_ebreak = 3'b000;
  localparam logic [2:0] funct3_csrrw  = 3'b001;
  localparam logic [2:0] funct3_csrrs  = 3'b010;
  localparam logic [2:0] funct3_csrrc  = 3'b011;
  localparam logic [2:0] funct3_csrrwi = 3'b101;
  localparam logic [2:0] funct3_csrrsi = 3'b110;
  localparam logic [2:0] funct3_csrrci = 3'b111;

  // mcause exception codes, interrupt bit not included
  localparam logic [30:0] trap_code_illegal_instr = 31'd2;
  localparam logic [30:0] trap_code_breakpoint    = 31'd3;
  localparam logic [30:0] trap_code_ecall_m_mode  = 31'd11;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } fetch_t;

endpackage

/* hw/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

  typedef enum logic [3:0] {
    mem_none, mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu, mem_sb, mem_sh, mem_sw
  } mem_op_t;

  typedef enum logic [1:0] {
    cf_none, cf_branch, cf_jump, cf_jalr
  } cf_op_t;

  typedef enum logic [2:0] {
    csr_none, csr_read, csr_write, csr_set, csr_clear
  } csr_op_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_ne, alu_lt, alu_ltu, alu_ge, alu_geu,
    alu_xor, alu_or, alu_and, alu_l_shift, alu_r_shift_l, alu_r_shift_a
  } alu_control_t;

  typedef enum logic [2:0] {
    imm_i_alu, imm_i_shift, imm_s, imm_b, imm_u, imm_j, imm_csr
  } imm_ext_op_t;

  typedef enum logic [1:0] {
    alu_a_reg_data, alu_a_pc, alu_a_zero
  } alu_a_sel_t;

  typedef enum logic {
    alu_b_reg_data, alu_b_imm
  } alu_b_sel_t;

  // base for branch / jump target adder
  typedef enum logic {
    pc_alu_pc, pc_alu_reg_data
  } pc_alu_sel_t;

  typedef enum logic [1:0] {
    result_alu, result_mem_data, result_next_instr_addr, result_csr_read_data
  } result_sel_t;

  typedef enum logic {
    csr_bitmask_reg_data, csr_bitmask_imm
  } csr_bitmask_sel_t;

  typedef struct packed {
    logic             rd_valid;
    logic             rs1_valid;
    logic             rs2_valid;
    mem_op_t          mem_op;
    cf_op_t           cf_op;
    csr_op_t          csr_op;
    alu_control_t     alu_control;
    imm_ext_op_t      imm_ext_op;
    alu_a_sel_t       alu_a_src;
    alu_b_sel_t       alu_b_src;
    pc_alu_sel_t      pc_alu_src;
    result_sel_t      result_src;
    csr_bitmask_sel_t csr_bitmask_sel;
  } ctrl_t;

  // everything execute needs from one instruction
  typedef struct packed {
    logic [31:0] pc;
    ctrl_t       ctrl;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rd_addr;
    logic [11:0] csr_addr;
    logic        trap_valid;
    logic [30:0] trap_mcause;
  } decoded_t;

endpackage

/* hw/pipe_reg.sv */
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  logic     flush,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  always_ff @(posedge clk) begin
    if (reset || flush)
      out_valid <= 1'b0;
    else if (!stall)
      out_valid <= in_valid;
  end

  always_ff @(posedge clk) begin
    if (!stall)
      out_data <= in_data;  // held while stalled
  end

endmodule

/* hw/imm_gen.sv */
module imm_gen (
  input  logic [31:0]              instr,
  input  rv_ctrl_pkg::imm_ext_op_t imm_ext_op,
  output logic [31:0]              imm
);
  import rv_ctrl_pkg::*;

  always_comb begin
    case (imm_ext_op)
      imm_i_alu:
        imm = {{20{instr[31]}}, instr[31:20]};
      imm_i_shift:
        imm = {27'd0, instr[24:20]};  // shamt
      imm_s:
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      imm_b:
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      imm_u:
        imm = {instr[31:12], 12'd0};
      imm_j:
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      imm_csr:
        imm = {27'd0, instr[19:15]};  // uimm sits in the rs1 field
      default:
        imm = 32'd0;
    endcase
  end

endmodule

/* hw/int_regfile.sv */
module int_regfile #(
  parameter int reg_count = 32
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        wb_en,
  input  logic [4:0]  wb_addr,
  input  logic [31:0] wb_data
);

  localparam int addr_w = $clog2(reg_count);

  logic [31:0]       regs [reg_count];
  logic [addr_w-1:0] rs1_idx;
  logic [addr_w-1:0] rs2_idx;
  logic [addr_w-1:0] wb_idx;

  // upper address bits unused in the 16 entry build
  assign rs1_idx = rs1_addr[addr_w-1:0];
  assign rs2_idx = rs2_addr[addr_w-1:0];
  assign wb_idx  = wb_addr[addr_w-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++)
        regs[i] <= 32'd0;
    end else if (wb_en && (wb_idx != '0)) begin
      regs[wb_idx] <= wb_data;
    end
  end

  // x0 hard-wired
  assign rs1_data = (rs1_idx == '0) ? 32'd0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? 32'd0 : regs[rs2_idx];

endmodule

/* hw/decoder.sv */
module decoder (
  input  logic [6:0]        op,
  input  logic [2:0]        funct3,
  input  logic [6:0]        funct7,
  input  logic [11:0]       funct12,
  input  logic [4:0]        rs1_addr,
  input  logic [4:0]        rd_addr,
  input  logic              rtype_alt,
  input  logic              itype_alt,
  output rv_ctrl_pkg::ctrl_t ctrl,
  output logic [30:0]       trap_mcause,
  output logic              trap_valid
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  // class of alu work, refined by funct3 below
  typedef enum logic [1:0] {
    aluop_add, aluop_branch, aluop_arith
  } alu_op_t;

  alu_op_t      alu_op;
  alu_control_t alu_control;
  logic         shift_left_or_logical;
  logic         shift_arith;
  logic         bad_rtype;
  logic         bad_itype;

  assign shift_left_or_logical = (funct3 == funct3_sll) || (funct3 == funct3_srl);
  assign shift_arith           = (funct3 == funct3_srl);
  // only sub and sra may carry funct7 = 0x20
  assign bad_rtype = (funct7 != 7'h00) &&
                     !((funct7 == 7'h20) && ((funct3 == funct3_add) || (funct3 == funct3_srl)));
  assign bad_itype = shift_left_or_logical && (funct7 != 7'h00) &&
                     !(shift_arith && (funct7 == 7'h20));

  always_comb begin
    trap_valid  = 1'b0;
    trap_mcause = trap_code_illegal_instr;
    alu_op      = aluop_add;
    ctrl.rd_valid        = 1'b0;
    ctrl.rs1_valid       = 1'b0;
    ctrl.rs2_valid       = 1'b0;
    ctrl.mem_op          = mem_none;
    ctrl.cf_op           = cf_none;
    ctrl.csr_op          = csr_none;
    ctrl.imm_ext_op      = imm_i_alu;
    ctrl.alu_a_src       = alu_a_reg_data;
    ctrl.alu_b_src       = alu_b_reg_data;
    ctrl.pc_alu_src      = pc_alu_pc;
    ctrl.result_src      = result_alu;
    ctrl.csr_bitmask_sel = csr_bitmask_reg_data;

    case (op)
      opcode_load: begin
        ctrl.rd_valid   = 1'b1;
        ctrl.rs1_valid  = 1'b1;
        ctrl.alu_b_src  = alu_b_imm;
        ctrl.result_src = result_mem_data;
        case (funct3)
          funct3_lb:  ctrl.mem_op = mem_lb;
          funct3_lh:  ctrl.mem_op = mem_lh;
          funct3_lw:  ctrl.mem_op = mem_lw;
          funct3_lbu: ctrl.mem_op = mem_lbu;
          funct3_lhu: ctrl.mem_op = mem_lhu;
          default:    trap_valid = 1'b1;
        endcase
      end
      opcode_store: begin
        ctrl.rs1_valid  = 1'b1;
        ctrl.rs2_valid  = 1'b1;
        ctrl.imm_ext_op = imm_s;
        ctrl.alu_b_src  = alu_b_imm;
        case (funct3)
          funct3_sb: ctrl.mem_op = mem_sb;
          funct3_sh: ctrl.mem_op = mem_sh;
          funct3_sw: ctrl.mem_op = mem_sw;
          default:   trap_valid = 1'b1;
        endcase
      end
      opcode_r_type: begin
        if (bad_rtype) begin
          trap_valid = 1'b1;
        end else begin
          ctrl.rd_valid  = 1'b1;
          ctrl.rs1_valid = 1'b1;
          ctrl.rs2_valid = 1'b1;
          alu_op         = aluop_arith;
        end
      end
      opcode_i_type: begin
        if (bad_itype) begin
          trap_valid = 1'b1;
        end else begin
          ctrl.rd_valid   = 1'b1;
          ctrl.rs1_valid  = 1'b1;
          ctrl.alu_b_src  = alu_b_imm;
          ctrl.imm_ext_op = shift_left_or_logical ? imm_i_shift : imm_i_alu;
          alu_op          = aluop_arith;
        end
      end
      opcode_b_type: begin
        ctrl.rs1_valid  = 1'b1;
        ctrl.rs2_valid  = 1'b1;
        ctrl.imm_ext_op = imm_b;
        ctrl.cf_op      = cf_branch;
        alu_op          = aluop_branch;  // compare rs1 against rs2
      end
      opcode_jal: begin
        ctrl.rd_valid   = 1'b1;
        ctrl.imm_ext_op = imm_j;
        ctrl.cf_op      = cf_jump;
        ctrl.result_src = result_next_instr_addr;
      end
      opcode_jalr: begin
        ctrl.rd_valid   = 1'b1;
        ctrl.rs1_valid  = 1'b1;
        ctrl.alu_b_src  = alu_b_imm;
        ctrl.cf_op      = cf_jalr;
        ctrl.pc_alu_src = pc_alu_reg_data;  // target is rs1 + imm
        ctrl.result_src = result_next_instr_addr;
      end
      opcode_u_type_lui: begin
        ctrl.rd_valid   = 1'b1;
        ctrl.imm_ext_op = imm_u;
        ctrl.alu_a_src  = alu_a_zero;
        ctrl.alu_b_src  = alu_b_imm;
      end
      opcode_u_type_auipc: begin
        ctrl.rd_valid   = 1'b1;
        ctrl.imm_ext_op = imm_u;
        ctrl.alu_a_src  = alu_a_pc;
        ctrl.alu_b_src  = alu_b_imm;
      end
      opcode_syscall_csr: begin
        if (funct3 == funct3_ecall_ebreak) begin
          trap_valid = 1'b1;
          if ((rs1_addr == 5'd0) && (rd_addr == 5'd0) && (funct12 == 12'h000))
            trap_mcause = trap_code_ecall_m_mode;
          else if ((rs1_addr == 5'd0) && (rd_addr == 5'd0) && (funct12 == 12'h001))
            trap_mcause = trap_code_breakpoint;
        end else if (funct3 == 3'b100) begin
          trap_valid = 1'b1;
        end else begin
          ctrl.rd_valid   = 1'b1;
          ctrl.result_src = result_csr_read_data;
          // funct3[2] picks the uimm forms
          ctrl.rs1_valid       = !funct3[2];
          ctrl.imm_ext_op      = funct3[2] ? imm_csr : imm_i_alu;
          ctrl.csr_bitmask_sel = funct3[2] ? csr_bitmask_imm : csr_bitmask_reg_data;
          case (funct3[1:0])
            2'b01:   ctrl.csr_op = csr_write;
            2'b10:   ctrl.csr_op = (rs1_addr == 5'd0) ? csr_read : csr_set;
            default: ctrl.csr_op = (rs1_addr == 5'd0) ? csr_read : csr_clear;
          endcase
        end
      end
      default: trap_valid = 1'b1;
    endcase

    ctrl.alu_control = alu_control;
  end

  always_comb begin
    alu_control = alu_add;
    case (alu_op)
      aluop_branch: begin
        case (funct3)
          funct3_beq:  alu_control = alu_sub;  // zero result means equal
          funct3_bne:  alu_control = alu_ne;
          funct3_blt:  alu_control = alu_lt;
          funct3_bge:  alu_control = alu_ge;
          funct3_bltu: alu_control = alu_ltu;
          funct3_bgeu: alu_control = alu_geu;
          default:     alu_control = alu_add;
        endcase
      end
      aluop_arith: begin
        case (funct3)
          funct3_add:  alu_control = rtype_alt ? alu_sub : alu_add;
          funct3_sll:  alu_control = alu_l_shift;
          funct3_slt:  alu_control = alu_lt;
          funct3_sltu: alu_control = alu_ltu;
          funct3_xor:  alu_control = alu_xor;
          funct3_srl:  alu_control = (rtype_alt || itype_alt) ? alu_r_shift_a : alu_r_shift_l;
          funct3_or:   alu_control = alu_or;
          default:     alu_control = alu_and;
        endcase
      end
      default: alu_control = alu_add;  // address and upper-imm adds
    endcase
  end

endmodule

/* hw/decode_stage.sv */
module decode_stage #(
  parameter int reg_count = 32
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fetch_valid,
  input  rv_isa_pkg::fetch_t    fetch,
  input  logic                  stall,
  input  logic                  flush,
  input  logic                  wb_en,
  input  logic [4:0]            wb_addr,
  input  logic [31:0]           wb_data,
  output logic                  ex_valid,
  output rv_ctrl_pkg::decoded_t ex
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic     fd_valid;
  fetch_t   fd;
  decoded_t de_in;

  pipe_reg #(.payload_t(fetch_t)) fd_reg (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .flush    (flush),
    .in_valid (fetch_valid),
    .in_data  (fetch),
    .out_valid(fd_valid),
    .out_data (fd)
  );

  assign de_in.pc       = fd.pc;
  assign de_in.rs1_addr = fd.instr[19:15];
  assign de_in.rs2_addr = fd.instr[24:20];
  assign de_in.rd_addr  = fd.instr[11:7];
  assign de_in.csr_addr = fd.instr[31:20];

  decoder u_decoder (
    .op         (fd.instr[6:0]),
    .funct3     (fd.instr[14:12]),
    .funct7     (fd.instr[31:25]),
    .funct12    (fd.instr[31:20]),
    .rs1_addr   (fd.instr[19:15]),
    .rd_addr    (fd.instr[11:7]),
    .rtype_alt  ((fd.instr[6:0] == opcode_r_type) && fd.instr[30]),
    .itype_alt  ((fd.instr[6:0] == opcode_i_type) && fd.instr[30]),
    .ctrl       (de_in.ctrl),
    .trap_mcause(de_in.trap_mcause),
    .trap_valid (de_in.trap_valid)
  );

  imm_gen u_imm_gen (
    .instr     (fd.instr),
    .imm_ext_op(de_in.ctrl.imm_ext_op),
    .imm       (de_in.imm)
  );

  int_regfile #(.reg_count(reg_count)) u_regfile (
    .clk     (clk),
    .reset   (reset),
    .rs1_addr(fd.instr[19:15]),
    .rs2_addr(fd.instr[24:20]),
    .rs1_data(de_in.rs1_data),
    .rs2_data(de_in.rs2_data),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  pipe_reg #(.payload_t(decoded_t)) de_reg (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .flush    (flush),
    .in_valid (fd_valid),
    .in_data  (de_in),
    .out_valid(ex_valid),
    .out_data (ex)
  );

endmodule

/* verification/tb_decode_stage.sv */
module tb_decode_stage;
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic     clk = 1'b0;
  logic     reset;
  logic     fetch_valid;
  fetch_t   fetch;
  logic     stall;
  logic     flush;
  logic     wb_en;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic     ex_valid;
  decoded_t ex;

  integer      seed;
  logic [31:0] reg_model [32];
  logic [31:0] pc_next;
  logic [31:0] instr;
  decoded_t    exp_q[$];
  int          stamp_q[$];
  decoded_t    expected;
  decoded_t    held_ex;
  int          issued_at;
  int          active_edges = 0;
  logic        stalled_edge = 1'b0;
  int          mismatch_count = 0;
  int          other_count = 0;

  decode_stage #(.reg_count(32)) DUT (
    .clk        (clk),
    .reset      (reset),
    .fetch_valid(fetch_valid),
    .fetch      (fetch),
    .stall      (stall),
    .flush      (flush),
    .wb_en      (wb_en),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data),
    .ex_valid   (ex_valid),
    .ex         (ex)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] imm_for_format(input logic [31:0] word, input imm_ext_op_t fmt);
    logic [31:0] imm;
    case (fmt)
      imm_i_shift: imm = {27'd0, word[24:20]};
      imm_s:       imm = {{20{word[31]}}, word[31:25], word[11:7]};
      imm_b:       imm = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
      imm_u:       imm = {word[31:12], 12'h000};
      imm_j:       imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
      imm_csr:     imm = {27'd0, word[19:15]};
      default:     imm = {{20{word[31]}}, word[31:20]};
    endcase
    return imm;
  endfunction

  function automatic alu_control_t alu_for_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? alu_sub : alu_add;
      3'd1:    return alu_l_shift;
      3'd2:    return alu_lt;
      3'd3:    return alu_ltu;
      3'd4:    return alu_xor;
      3'd5:    return alt ? alu_r_shift_a : alu_r_shift_l;
      3'd6:    return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic decoded_t ref_decode(input logic [31:0] word, input logic [31:0] pc);
    decoded_t    d;
    imm_ext_op_t fmt;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        no_rs1;
    f3 = word[14:12];
    f7 = word[31:25];
    no_rs1 = (word[19:15] == 5'd0);
    fmt = imm_i_alu;
    d = '0;
    d.pc = pc;
    d.rs1_addr = word[19:15];
    d.rs2_addr = word[24:20];
    d.rd_addr = word[11:7];
    d.csr_addr = word[31:20];
    d.rs1_data = reg_model[word[19:15]];
    d.rs2_data = reg_model[word[24:20]];
    d.trap_mcause = trap_code_illegal_instr;
    case (word[6:0])
      opcode_load: begin
        d.ctrl.rd_valid = 1'b1;
        d.ctrl.rs1_valid = 1'b1;
        d.ctrl.alu_b_src = alu_b_imm;
        d.ctrl.result_src = result_mem_data;
        if (f3 == 3'd0) d.ctrl.mem_op = mem_lb;
        else if (f3 == 3'd1) d.ctrl.mem_op = mem_lh;
        else if (f3 == 3'd2) d.ctrl.mem_op = mem_lw;
        else if (f3 == 3'd4) d.ctrl.mem_op = mem_lbu;
        else if (f3 == 3'd5) d.ctrl.mem_op = mem_lhu;
        else d.trap_valid = 1'b1;
      end
      opcode_store: begin
        d.ctrl.rs1_valid = 1'b1;
        d.ctrl.rs2_valid = 1'b1;
        d.ctrl.alu_b_src = alu_b_imm;
        fmt = imm_s;
        if (f3 == 3'd0) d.ctrl.mem_op = mem_sb;
        else if (f3 == 3'd1) d.ctrl.mem_op = mem_sh;
        else if (f3 == 3'd2) d.ctrl.mem_op = mem_sw;
        else d.trap_valid = 1'b1;
      end
      opcode_r_type: begin
        d.ctrl.rd_valid = 1'b1;
        d.ctrl.rs1_valid = 1'b1;
        d.ctrl.rs2_valid = 1'b1;
        d.ctrl.alu_control = alu_for_funct3(f3, word[30]);
        // 0x20 is only sub and sra
        if (!(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))))
          d.trap_valid = 1'b1;
      end
      opcode_i_type: begin
        d.ctrl.rd_valid = 1'b1;
        d.ctrl.rs1_valid = 1'b1;
        d.ctrl.alu_b_src = alu_b_imm;
        d.ctrl.alu_control = alu_for_funct3(f3, (f3 == 3'd5) && word[30]);
        if (f3 == 3'd1 || f3 == 3'd5) begin
          fmt = imm_i_shift;
          if (!(f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)))
            d.trap_valid = 1'b1;
        end
      end
      opcode_b_type: begin
        d.ctrl.rs1_valid = 1'b1;
        d.ctrl.rs2_valid = 1'b1;
        d.ctrl.cf_op = cf_branch;
        fmt = imm_b;
        if (f3 == 3'd0) d.ctrl.alu_control = alu_sub;
        else if (f3 == 3'd1) d.ctrl.alu_control = alu_ne;
        else if (f3 == 3'd4) d.ctrl.alu_control = alu_lt;
        else if (f3 == 3'd5) d.ctrl.alu_control = alu_ge;
        else if (f3 == 3'd6) d.ctrl.alu_control = alu_ltu;
        else d.ctrl.alu_control = alu_geu;
      end
      opcode_jal: begin
        d.ctrl.rd_valid = 1'b1;
        d.ctrl.cf_op = cf_jump;
        d.ctrl.result_src = result_next_instr_addr;
        fmt = imm_j;
      end
      opcode_jalr: begin
        d.ctrl.rd_valid = 1'b1;
        d.ctrl.rs1_valid = 1'b1;
        d.ctrl.alu_b_src = alu_b_imm;
        d.ctrl.cf_op = cf_jalr;
        d.ctrl.pc_alu_src = pc_alu_reg_data;
        d.ctrl.result_src = result_next_instr_addr;
      end
      opcode_u_type_lui, opcode_u_type_auipc: begin
        d.ctrl.rd_valid = 1'b1;
        d.ctrl.alu_a_src = (word[6:0] == opcode_u_type_lui) ? alu_a_zero : alu_a_pc;
        d.ctrl.alu_b_src = alu_b_imm;
        fmt = imm_u;
      end
      opcode_syscall_csr: begin
        if (f3 == 3'd0 || f3 == 3'd4) begin
          d.trap_valid = 1'b1;
          if (f3 == 3'd0 && no_rs1 && word[11:7] == 5'd0 && word[31:20] == 12'd0)
            d.trap_mcause = trap_code_ecall_m_mode;
          if (f3 == 3'd0 && no_rs1 && word[11:7] == 5'd0 && word[31:20] == 12'd1)
            d.trap_mcause = trap_code_breakpoint;
        end else begin
          d.ctrl.rd_valid = 1'b1;
          d.ctrl.result_src = result_csr_read_data;
          d.ctrl.rs1_valid = (f3 < 3'd4);
          fmt = (f3 < 3'd4) ? imm_i_alu : imm_csr;
          d.ctrl.csr_bitmask_sel = (f3 < 3'd4) ? csr_bitmask_reg_data : csr_bitmask_imm;
          if (f3[1:0] == 2'd1) d.ctrl.csr_op = csr_write;
          else if (no_rs1) d.ctrl.csr_op = csr_read;  // set/clear with no mask bits
          else if (f3[1:0] == 2'd2) d.ctrl.csr_op = csr_set;
          else d.ctrl.csr_op = csr_clear;
        end
      end
      default: d.trap_valid = 1'b1;
    endcase
    d.ctrl.imm_ext_op = fmt;
    d.imm = imm_for_format(word, fmt);
    return d;
  endfunction

  function automatic logic [31:0] illegal_instr(input int k);
    case (k)
      0:       return 32'h00000073;  // ecall
      1:       return 32'h00100073;  // ebreak
      2:       return 32'h000000f3;  // ecall with rd set
      3:       return 32'h00200073;
      4:       return 32'h0000000b;  // custom-0 opcode
      5:       return 32'h00003003;
      6:       return 32'h00003023;
      7:       return 32'h02000033;  // mul
      8:       return 32'h40004033;
      9:       return 32'h40001013;
      10:      return 32'h02005013;
      default: return 32'h00004073;
    endcase
  endfunction

  task automatic gen_legal_instr(output logic [31:0] word);
    logic [31:0] r;
    int          kind;
    logic [4:0]  rs1;
    logic [2:0]  f3;
    r = $random(seed);
    kind = $unsigned($random(seed)) % 9;
    rs1 = r[19:15];
    f3 = r[14:12];
    case (kind)
      0: word = {((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00, r[24:15], f3, r[11:7],
                 opcode_r_type};
      1: begin
        word = {r[31:15], f3, r[11:7], opcode_i_type};
        if (f3 == 3'd1 || f3 == 3'd5)
          word[31:25] = (f3 == 3'd5 && r[30]) ? 7'h20 : 7'h00;
      end
      2: begin
        if (f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7)
          f3 = 3'd5;
        word = {r[31:15], f3, r[11:7], opcode_load};
      end
      3: word = {r[31:15], (r[13:12] == 2'd3) ? 3'd2 : {1'b0, r[13:12]}, r[11:7], opcode_store};
      4: begin
        if (f3 == 3'd2 || f3 == 3'd3)
          f3[2] = 1'b1;
        word = {r[31:15], f3, r[11:7], opcode_b_type};
      end
      5: word = {r[31:7], opcode_jal};
      6: word = {r[31:15], 3'd0, r[11:7], opcode_jalr};
      7: word = {r[31:7], r[0] ? opcode_u_type_lui : opcode_u_type_auipc};
      default: begin
        if (f3 == 3'd0 || f3 == 3'd4)
          f3 = 3'd2;
        if (r[3:2] == 2'd0)
          rs1 = 5'd0;
        word = {r[31:20], rs1, f3, r[11:7], opcode_syscall_csr};
      end
    endcase
  endtask

  task automatic issue_fetch(input logic [31:0] word);
    @(negedge clk);
    fetch_valid = 1'b1;
    fetch.pc = pc_next;
    fetch.instr = word;
    wb_en = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    exp_q.push_back(ref_decode(word, pc_next));
    stamp_q.push_back(active_edges);
    pc_next = pc_next + 32'd4;
  endtask

  task automatic idle_cycle;
    @(negedge clk);
    fetch_valid = 1'b0;
    wb_en = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    @(negedge clk);
    fetch_valid = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    wb_en = 1'b1;
    wb_addr = addr;
    wb_data = data;
    if (addr != 5'd0)
      reg_model[addr] = data;
  endtask

  task automatic stall_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      fetch_valid = 1'b0;
      wb_en = 1'b0;
      stall = 1'b1;
    end
  endtask

  // the fetch presented with the flush is dropped as well
  task automatic flush_pipe;
    @(negedge clk);
    fetch_valid = 1'b1;
    fetch.instr = 32'h00000013;
    wb_en = 1'b0;
    stall = 1'b0;
    flush = 1'b1;
    exp_q.delete();
    stamp_q.delete();
  endtask

  task automatic wait_drain;
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: no ex_valid for instruction at pc %h within 20 cycles", exp_q[0].pc);
      other_count++;
    end
  endtask

  task automatic check_field(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("MISMATCH %s expected %h actual %h", name, exp_val, act_val);
      mismatch_count++;
    end
  endtask

  task automatic compare_bundle(input decoded_t e);
    check_field("pc", e.pc, ex.pc);
    check_field("rs1_addr", e.rs1_addr, ex.rs1_addr);
    check_field("rs2_addr", e.rs2_addr, ex.rs2_addr);
    check_field("rd_addr", e.rd_addr, ex.rd_addr);
    check_field("csr_addr", e.csr_addr, ex.csr_addr);
    check_field("rs1_data", e.rs1_data, ex.rs1_data);
    check_field("rs2_data", e.rs2_data, ex.rs2_data);
    check_field("trap_valid", e.trap_valid, ex.trap_valid);
    if (e.trap_valid)
      check_field("trap_mcause", e.trap_mcause, ex.trap_mcause);
    if (!e.trap_valid) begin  // controls are don't-care on a trap
      check_field("rd_valid", e.ctrl.rd_valid, ex.ctrl.rd_valid);
      check_field("rs1_valid", e.ctrl.rs1_valid, ex.ctrl.rs1_valid);
      check_field("rs2_valid", e.ctrl.rs2_valid, ex.ctrl.rs2_valid);
      check_field("mem_op", e.ctrl.mem_op, ex.ctrl.mem_op);
      check_field("cf_op", e.ctrl.cf_op, ex.ctrl.cf_op);
      check_field("csr_op", e.ctrl.csr_op, ex.ctrl.csr_op);
      check_field("alu_control", e.ctrl.alu_control, ex.ctrl.alu_control);
      check_field("imm_ext_op", e.ctrl.imm_ext_op, ex.ctrl.imm_ext_op);
      check_field("alu_a_src", e.ctrl.alu_a_src, ex.ctrl.alu_a_src);
      check_field("alu_b_src", e.ctrl.alu_b_src, ex.ctrl.alu_b_src);
      check_field("pc_alu_src", e.ctrl.pc_alu_src, ex.ctrl.pc_alu_src);
      check_field("result_src", e.ctrl.result_src, ex.ctrl.result_src);
      check_field("csr_bitmask_sel", e.ctrl.csr_bitmask_sel, ex.ctrl.csr_bitmask_sel);
      check_field("imm", e.imm, ex.imm);
    end
  endtask

  // count only edges that move the pipeline
  always @(posedge clk) begin
    stalled_edge <= stall;
    if (!stall)
      active_edges <= active_edges + 1;
  end

  always @(negedge clk) begin
    if (ex_valid === 1'b1) begin
      if (stalled_edge) begin
        if (ex !== held_ex) begin
          $display("ex changed while the pipeline was stalled (pc %h)", ex.pc);
          other_count++;
        end
      end else if (exp_q.size() == 0) begin
        $display("ex_valid high with no instruction in flight (pc %h)", ex.pc);
        other_count++;
      end else begin
        expected = exp_q.pop_front();
        issued_at = stamp_q.pop_front();
        if (active_edges - issued_at != 2) begin
          $display("instruction at pc %h arrived after %0d cycles instead of 2",
                   ex.pc, active_edges - issued_at);
          other_count++;
        end
        compare_bundle(expected);
        held_ex = ex;
      end
    end
  end

  initial begin
    seed = 55097;
    reset = 1'b1;
    fetch_valid = 1'b0;
    fetch = '0;
    stall = 1'b0;
    flush = 1'b0;
    wb_en = 1'b0;
    wb_addr = 5'd0;
    wb_data = 32'd0;
    pc_next = 32'h0000_1000;
    for (int i = 0; i < 32; i++)
      reg_model[i] = 32'd0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    for (int i = 1; i < 32; i++)
      write_reg(i[4:0], $random(seed));

    // mixed legal and illegal, back to back
    for (int i = 0; i < 80; i++) begin
      if ($unsigned($random(seed)) % 6 == 0)
        instr = illegal_instr($unsigned($random(seed)) % 12);
      else
        gen_legal_instr(instr);
      issue_fetch(instr);
    end
    idle_cycle();
    wait_drain();

    for (int k = 0; k < 12; k++)
      issue_fetch(illegal_instr(k));
    issue_fetch(32'h402081b3);  // sub x3, x1, x2
    issue_fetch(32'h4020d1b3);  // sra x3, x1, x2
    issue_fetch(32'h4050d193);  // srai x3, x1, 5
    issue_fetch(32'h300022f3);  // csrrs x5, mstatus, x0
    issue_fetch(32'h34107073);  // csrrci x0, mepc, 0
    idle_cycle();
    wait_drain();

    issue_fetch(32'h002081b3);
    issue_fetch(32'h0040c233);
    stall_cycles(3);
    idle_cycle();
    wait_drain();

    issue_fetch(32'h00308133);
    flush_pipe();
    idle_cycle();
    repeat (6) idle_cycle();
    issue_fetch(32'h00a00093);
    idle_cycle();
    wait_drain();

    write_reg(5'd0, 32'hdeadbeef);
    write_reg(5'd7, 32'h12345678);
    issue_fetch({7'h00, 5'd7, 5'd0, 3'b000, 5'd8, opcode_r_type});
    issue_fetch({7'h00, 5'd0, 5'd0, 3'b000, 5'd9, opcode_r_type});
    idle_cycle();
    wait_drain();

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* src.f */
hw/rv_isa_pkg.sv
hw/rv_ctrl_pkg.sv
hw/pipe_reg.sv
hw/imm_gen.sv
hw/int_regfile.sv
hw/decoder.sv
hw/decode_stage.sv
verification/tb_decode_stage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - hw/rv_isa_pkg.sv
  - hw/rv_ctrl_pkg.sv
  - hw/pipe_reg.sv
  - hw/imm_gen.sv
  - hw/int_regfile.sv
  - hw/decoder.sv
  - hw/decode_stage.sv
  - target: test
    files:
      - verification/tb_decode_stage.sv
